//--- common/cpu_pkg.sv
package cpu_pkg;

    // widths
    localparam int len_word      = 32;
    localparam int len_reg_addr  = 5;
    localparam int len_imem_addr = 10;
    localparam int len_dmem_addr = 10;

    // one-hot sequencer bit positions
    localparam int len_state       = 6;
    localparam int st_fetch        = 0;
    localparam int st_fetch_wait   = 1;
    localparam int st_decode       = 2;
    localparam int st_execute      = 3;
    localparam int st_execute_wait = 4;
    localparam int st_write        = 5;

    // rv32i opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // alu funct3
    localparam logic [2:0] f3_add  = 3'd0;
    localparam logic [2:0] f3_sll  = 3'd1;
    localparam logic [2:0] f3_slt  = 3'd2;
    localparam logic [2:0] f3_sltu = 3'd3;
    localparam logic [2:0] f3_xor  = 3'd4;
    localparam logic [2:0] f3_sr   = 3'd5;
    localparam logic [2:0] f3_or   = 3'd6;
    localparam logic [2:0] f3_and  = 3'd7;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'd0;
    localparam logic [2:0] f3_bne  = 3'd1;
    localparam logic [2:0] f3_blt  = 3'd4;
    localparam logic [2:0] f3_bge  = 3'd5;
    localparam logic [2:0] f3_bltu = 3'd6;
    localparam logic [2:0] f3_bgeu = 3'd7;

    // access size funct3
    localparam logic [2:0] f3_b  = 3'd0;
    localparam logic [2:0] f3_h  = 3'd1;
    localparam logic [2:0] f3_w  = 3'd2;
    localparam logic [2:0] f3_bu = 3'd4;
    localparam logic [2:0] f3_hu = 3'd5;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, read through whichever format applies
    typedef union packed {
        logic [len_word-1:0] raw;
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    typedef enum logic [2:0] {
        unit_alu,
        unit_mem,
        unit_branch,
        unit_jump,
        unit_upper
    } unit_t;

    typedef struct packed {
        unit_t                   unit;
        logic                    use_imm;
        logic                    alt;
        logic [2:0]              funct3;
        logic [len_reg_addr-1:0] rd;
        logic                    wr_en;
        logic                    is_store;
        logic [len_word-1:0]     op_a;
        logic [len_word-1:0]     op_b;
        logic [len_word-1:0]     target;
        logic [len_word-1:0]     store_data;
    } dec_t;

endpackage

//--- verilog/regs.sv
`timescale 1ns/1ps

module regs (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             write,
    input  logic [cpu_pkg::len_reg_addr-1:0] rd,
    input  logic [cpu_pkg::len_word-1:0]     wdata,
    input  logic [cpu_pkg::len_reg_addr-1:0] rs1,
    input  logic [cpu_pkg::len_reg_addr-1:0] rs2,
    output logic [cpu_pkg::len_word-1:0]     rdata1,
    output logic [cpu_pkg::len_word-1:0]     rdata2
);
    import cpu_pkg::*;

    logic [len_word-1:0] mem [2**len_reg_addr];

    // x0 is cleared by reset and never written afterwards
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2**len_reg_addr; i++) begin
                mem[i] <= '0;
            end
        end else if (write && rd != '0) begin
            mem[rd] <= wdata;
        end
    end

    assign rdata1 = mem[rs1];
    assign rdata2 = mem[rs2];

endmodule

//--- verilog/fetch.sv
`timescale 1ns/1ps

module fetch (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              order,
    input  logic [cpu_pkg::len_word-1:0]      pc,
    output logic                              fetched,
    output cpu_pkg::inst_t                    inst,
    output logic [cpu_pkg::len_imem_addr-1:0] a_inst,
    input  logic [cpu_pkg::len_word-1:0]      d_inst
);
    import cpu_pkg::*;

    logic  issued;
    inst_t inst_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            issued  <= 1'b0;
            fetched <= 1'b0;
        end else begin
            issued  <= order;
            fetched <= issued;
        end
    end

    // word address, then the returned word kept for decode
    always_ff @(posedge clk) begin
        if (order) begin
            a_inst <= pc[len_imem_addr+1:2];
        end
        if (fetched) begin
            inst_q <= d_inst;
        end
    end

    // memory word is live in the fetched cycle only
    assign inst = fetched ? inst_t'(d_inst) : inst_q;

endmodule

//--- decode/decode.sv
`timescale 1ns/1ps

module decode (
    input  cpu_pkg::inst_t                   inst,
    input  logic [cpu_pkg::len_word-1:0]     pc,
    output logic [cpu_pkg::len_reg_addr-1:0] a_rs1,
    output logic [cpu_pkg::len_reg_addr-1:0] a_rs2,
    input  logic [cpu_pkg::len_word-1:0]     d_rs1,
    input  logic [cpu_pkg::len_word-1:0]     d_rs2,
    output cpu_pkg::dec_t                    dec
);
    import cpu_pkg::*;

    logic [len_word-1:0] i_imm;
    logic [len_word-1:0] s_imm;
    logic [len_word-1:0] b_imm;
    logic [len_word-1:0] u_imm;
    logic [len_word-1:0] j_imm;

    assign a_rs1 = inst.r_fmt.rs1;
    assign a_rs2 = inst.r_fmt.rs2;

    // sign-extended immediates per format
    assign i_imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign s_imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign b_imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign u_imm = {inst.u_fmt.imm, 12'b0};
    assign j_imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        dec            = '0;
        dec.unit       = unit_alu;
        dec.funct3     = inst.r_fmt.funct3;
        dec.rd         = inst.r_fmt.rd;
        dec.op_a       = d_rs1;
        dec.op_b       = d_rs2;
        dec.store_data = d_rs2;
        case (inst.r_fmt.opcode)
            op_lui: begin
                dec.unit   = unit_upper;
                dec.wr_en  = 1'b1;
                dec.target = u_imm;
            end
            op_auipc: begin
                dec.unit   = unit_upper;
                dec.wr_en  = 1'b1;
                dec.op_a   = pc;
                dec.target = pc + u_imm;
            end
            op_jal: begin
                dec.unit   = unit_jump;
                dec.wr_en  = 1'b1;
                dec.target = pc + j_imm;
            end
            op_jalr: begin
                dec.unit   = unit_jump;
                dec.wr_en  = 1'b1;
                dec.target = d_rs1 + i_imm;
            end
            op_branch: begin
                dec.unit   = unit_branch;
                dec.target = pc + b_imm;
            end
            op_load: begin
                dec.unit    = unit_mem;
                dec.use_imm = 1'b1;
                dec.wr_en   = 1'b1;
                dec.op_b    = i_imm;
            end
            op_store: begin
                dec.unit     = unit_mem;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                dec.op_b     = s_imm;
            end
            op_imm: begin
                dec.use_imm = 1'b1;
                dec.wr_en   = 1'b1;
                dec.alt     = inst.raw[30];
                dec.op_b    = i_imm;
            end
            op_reg: begin
                dec.wr_en = 1'b1;
                dec.alt   = inst.raw[30];
            end
            // anything else retires as a no-op
            default: ;
        endcase
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::dec_t                dec,
    output logic [cpu_pkg::len_word-1:0] result,
    output logic                         branch_taken
);
    import cpu_pkg::*;

    logic [4:0]          shamt;
    logic [len_word-1:0] sra;
    logic                lt_s;
    logic                lt_u;
    logic                eq;

    assign shamt = dec.op_b[4:0];
    assign sra   = $signed(dec.op_a) >>> shamt;
    // compares shared by slt and the branches
    assign lt_s  = $signed(dec.op_a) < $signed(dec.op_b);
    assign lt_u  = dec.op_a < dec.op_b;
    assign eq    = dec.op_a == dec.op_b;

    always_comb begin
        case (dec.funct3)
            // addi has no sub form
            f3_add:  result = (dec.alt && !dec.use_imm) ? dec.op_a - dec.op_b
                                                        : dec.op_a + dec.op_b;
            f3_sll:  result = dec.op_a << shamt;
            f3_slt:  result = {31'b0, lt_s};
            f3_sltu: result = {31'b0, lt_u};
            f3_xor:  result = dec.op_a ^ dec.op_b;
            f3_sr:   result = dec.alt ? sra : dec.op_a >> shamt;
            f3_or:   result = dec.op_a | dec.op_b;
            default: result = dec.op_a & dec.op_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            f3_beq:  branch_taken = eq;
            f3_bne:  branch_taken = !eq;
            f3_blt:  branch_taken = lt_s;
            f3_bge:  branch_taken = !lt_s;
            f3_bltu: branch_taken = lt_u;
            f3_bgeu: branch_taken = !lt_u;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- verilog/memory.sv
`timescale 1ns/1ps

module memory (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              flag,
    input  cpu_pkg::dec_t                     dec,
    output logic                              accessed,
    output logic [cpu_pkg::len_word-1:0]      load_data,
    output logic [cpu_pkg::len_dmem_addr-1:0] a_mem,
    output logic [cpu_pkg::len_word-1:0]      sd_mem,
    input  logic [cpu_pkg::len_word-1:0]      ld_mem,
    output logic [3:0]                        mem_write_flag,
    output logic                              mem_read_flag
);
    import cpu_pkg::*;

    logic [len_word-1:0] addr;
    logic [3:0]          be;
    logic [len_word-1:0] wdata;
    logic [1:0]          offset;
    logic [2:0]          funct3;
    logic [7:0]          lane_b;
    logic [15:0]         lane_h;

    assign addr = dec.op_a + dec.op_b;

    // lanes and replicated data; misaligned halves fall back to the lower lane
    always_comb begin
        case (dec.funct3[1:0])
            2'd0: begin
                be    = 4'b0001 << addr[1:0];
                wdata = {4{dec.store_data[7:0]}};
            end
            2'd1: begin
                be    = 4'b0011 << {addr[1], 1'b0};
                wdata = {2{dec.store_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = dec.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_write_flag <= '0;
            mem_read_flag  <= 1'b0;
            accessed       <= 1'b0;
        end else begin
            mem_write_flag <= (flag && dec.is_store) ? be : 4'b0;
            mem_read_flag  <= flag && !dec.is_store;
            accessed       <= mem_read_flag || mem_write_flag != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (flag) begin
            a_mem  <= addr[len_dmem_addr+1:2];
            sd_mem <= wdata;
            offset <= addr[1:0];
            funct3 <= dec.funct3;
        end
    end

    assign lane_b = ld_mem[8*offset +: 8];
    assign lane_h = ld_mem[16*offset[1] +: 16];

    always_comb begin
        case (funct3)
            f3_b:    load_data = {{24{lane_b[7]}}, lane_b};
            f3_bu:   load_data = {24'b0, lane_b};
            f3_h:    load_data = {{16{lane_h[15]}}, lane_h};
            f3_hu:   load_data = {16'b0, lane_h};
            f3_w:    load_data = ld_mem;
            default: load_data = ld_mem;
        endcase
    end

endmodule

//--- cpu/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                              clk,
    input  logic                              rstn,
    output logic [cpu_pkg::len_imem_addr-1:0] a_inst,
    input  logic [cpu_pkg::len_word-1:0]      d_inst,
    output logic [cpu_pkg::len_dmem_addr-1:0] a_mem,
    output logic [cpu_pkg::len_word-1:0]      sd_mem,
    input  logic [cpu_pkg::len_word-1:0]      ld_mem,
    output logic [3:0]                        mem_write_flag,
    output logic                              mem_read_flag
);
    import cpu_pkg::*;

    logic [len_word-1:0]     pc;
    logic [len_state-1:0]    state;

    // fetch side
    logic                    fetch_order;
    logic                    fetched;
    inst_t                   inst_f;
    inst_t                   inst_q;
    logic [len_word-1:0]     pc_q;

    // decode and register file
    logic [len_reg_addr-1:0] a_rs1;
    logic [len_reg_addr-1:0] a_rs2;
    logic [len_word-1:0]     d_rs1;
    logic [len_word-1:0]     d_rs2;
    dec_t                    dec_d;
    dec_t                    dec_q;

    // execute and write back
    logic [len_word-1:0]     alu_result;
    logic                    branch_taken;
    logic                    mem_flag;
    logic                    accessed;
    logic [len_word-1:0]     load_data;
    logic                    wb_en;
    logic [len_word-1:0]     wb_data;
    logic [len_word-1:0]     next_pc;
    logic [len_word-1:0]     pc_plus4;
    logic                    reg_write;

    assign pc_plus4  = pc_q + 32'd4;
    assign reg_write = state[st_write] && wb_en;

    regs i_regs (
        .clk(clk), .rstn(rstn), .write(reg_write), .rd(dec_q.rd), .wdata(wb_data),
        .rs1(a_rs1), .rs2(a_rs2), .rdata1(d_rs1), .rdata2(d_rs2)
    );

    fetch i_fetch (
        .clk(clk), .rstn(rstn), .order(fetch_order), .pc(pc), .fetched(fetched),
        .inst(inst_f), .a_inst(a_inst), .d_inst(d_inst)
    );

    decode i_decode (
        .inst(inst_q), .pc(pc_q), .a_rs1(a_rs1), .a_rs2(a_rs2),
        .d_rs1(d_rs1), .d_rs2(d_rs2), .dec(dec_d)
    );

    alu i_alu (
        .dec(dec_q), .result(alu_result), .branch_taken(branch_taken)
    );

    memory i_memory (
        .clk(clk), .rstn(rstn), .flag(mem_flag), .dec(dec_q), .accessed(accessed),
        .load_data(load_data), .a_mem(a_mem), .sd_mem(sd_mem), .ld_mem(ld_mem),
        .mem_write_flag(mem_write_flag), .mem_read_flag(mem_read_flag)
    );

    // leave reset through write, which issues the first fetch at pc 0
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= len_state'(1) << st_write;
            pc          <= '0;
            next_pc     <= '0;
            wb_en       <= 1'b0;
            fetch_order <= 1'b0;
            mem_flag    <= 1'b0;
        end else begin
            // both orders are one-cycle strobes into the next state
            fetch_order <= state[st_write];
            mem_flag    <= state[st_decode] && dec_d.unit == unit_mem;
            case (1'b1)
                state[st_fetch]: begin
                    state <= len_state'(1) << st_fetch_wait;
                end
                state[st_fetch_wait]: begin
                    if (fetched) begin
                        inst_q <= inst_f;
                        pc_q   <= pc;
                        state  <= len_state'(1) << st_decode;
                    end
                end
                state[st_decode]: begin
                    dec_q <= dec_d;
                    state <= len_state'(1) << st_execute;
                end
                state[st_execute]: begin
                    wb_en   <= dec_q.wr_en;
                    next_pc <= pc_plus4;
                    state   <= len_state'(1) << st_write;
                    case (dec_q.unit)
                        unit_mem:    state <= len_state'(1) << st_execute_wait;
                        unit_branch: next_pc <= branch_taken ? dec_q.target : pc_plus4;
                        unit_jump: begin
                            wb_data <= pc_plus4;
                            next_pc <= dec_q.target;
                        end
                        unit_upper:  wb_data <= dec_q.target;
                        default:     wb_data <= alu_result;
                    endcase
                end
                state[st_execute_wait]: begin
                    // stores come back here too, with wb_en already low
                    if (accessed) begin
                        wb_data <= load_data;
                        state   <= len_state'(1) << st_write;
                    end
                end
                state[st_write]: begin
                    pc    <= {next_pc[len_word-1:2], 2'b00};
                    state <= len_state'(1) << st_fetch;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- tb/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts (
    input logic                            clk,
    input logic                            rstn,
    input logic                            fetch_order,
    input logic                            fetched,
    input logic                            mem_flag,
    input logic                            accessed,
    input logic [3:0]                      mem_write_flag,
    input logic                            mem_read_flag,
    input logic                            reg_write,
    input logic [cpu_pkg::len_state-1:0]   state
);

    // data port never reads and writes in one cycle
    a_rw_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_read_flag && mem_write_flag != '0))
        else $error("read and write strobes active together");

    a_fetch_lat: assert property (@(posedge clk) disable iff (!rstn)
        fetch_order |-> ##2 fetched)
        else $error("fetched did not follow fetch_order after 2 cycles");

    a_fetch_src: assert property (@(posedge clk) disable iff (!rstn)
        fetched |-> $past(fetch_order, 2))
        else $error("fetched without a fetch_order 2 cycles earlier");

    a_mem_lat: assert property (@(posedge clk) disable iff (!rstn)
        mem_flag |-> ##2 accessed)
        else $error("accessed did not follow mem_flag after 2 cycles");

    a_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot(state))
        else $error("sequencer state is not one-hot");

    // one reset edge is enough to clear the strobes
    a_reset: assert property (@(posedge clk) $past(!rstn) |->
        !fetch_order && !fetched && !mem_flag && mem_write_flag == '0
        && !mem_read_flag && !accessed && !reg_write)
        else $error("control strobe active during reset");

endmodule

bind cpu cpu_asserts i_asserts (
    .clk(clk), .rstn(rstn), .fetch_order(fetch_order), .fetched(fetched),
    .mem_flag(mem_flag), .accessed(accessed), .mem_write_flag(mem_write_flag),
    .mem_read_flag(mem_read_flag), .reg_write(reg_write), .state(state)
);

//--- tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    typedef struct packed {
        logic [9:0]  addr;
        logic [3:0]  be;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rstn;
    logic [9:0]  a_inst;
    logic [31:0] d_inst;
    logic [9:0]  a_mem;
    logic [31:0] sd_mem;
    logic [31:0] ld_mem;
    logic [3:0]  mem_write_flag;
    logic        mem_read_flag;

    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    logic [31:0] lfsr = 32'd66;
    int          pc_gen;
    int          slot;
    logic [31:0] end_pc;
    logic        gen_done = 1'b0;

    // architectural model
    logic [31:0] r_pc;
    logic [31:0] r_x [32];
    logic [31:0] r_mem [1024];
    store_t      exp_q[$];

    cpu i_dut (
        .clk(clk), .rstn(rstn), .a_inst(a_inst), .d_inst(d_inst), .a_mem(a_mem),
        .sd_mem(sd_mem), .ld_mem(ld_mem), .mem_write_flag(mem_write_flag),
        .mem_read_flag(mem_read_flag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rnd(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] byte_mask(logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic void emit(logic [31:0] w);
        imem[10'(pc_gen)] = w;
        pc_gen++;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // word store of a register to the next fresh data word
    function automatic void store_slot(logic [4:0] rs);
        emit(enc_s(12'(slot), rs, 5'd0, f3_w));
        slot += 4;
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic is_reg,
                                            logic [31:0] a, logic [31:0] b);
        logic [31:0] sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'd0: return (alt && is_reg) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? sra : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_cond(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // one instruction of the architectural model
    function automatic void ref_exec();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] nxt;
        logic [31:0] ld;
        logic [31:0] data;
        logic [3:0]  be;
        logic        wr;
        w = imem[r_pc[11:2]];
        a = r_x[w[19:15]];
        b = r_x[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        nxt = r_pc + 32'd4;
        wr = 1'b1;
        res = '0;
        case (w[6:0])
            op_lui: res = {w[31:12], 12'b0};
            op_auipc: res = r_pc + {w[31:12], 12'b0};
            op_jal: begin
                res = nxt;
                nxt = r_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            op_jalr: begin
                res = nxt;
                nxt = (a + imm_i) & ~32'd3;
            end
            op_branch: begin
                wr = 1'b0;
                if (br_cond(w[14:12], a, b)) begin
                    nxt = r_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            op_load: begin
                addr = a + imm_i;
                ld = r_mem[addr[11:2]] >> (8 * addr[1:0]);
                case (w[14:12])
                    f3_b: res = {{24{ld[7]}}, ld[7:0]};
                    f3_bu: res = {24'b0, ld[7:0]};
                    f3_h: res = {{16{ld[15]}}, ld[15:0]};
                    f3_hu: res = {16'b0, ld[15:0]};
                    default: res = r_mem[addr[11:2]];
                endcase
            end
            op_store: begin
                wr = 1'b0;
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                case (w[14:12])
                    f3_b: begin
                        be = 4'b0001 << addr[1:0];
                        data = {4{b[7:0]}};
                    end
                    f3_h: begin
                        be = 4'b0011 << addr[1:0];
                        data = {2{b[15:0]}};
                    end
                    default: begin
                        be = 4'b1111;
                        data = b;
                    end
                endcase
                r_mem[addr[11:2]] = (r_mem[addr[11:2]] & ~byte_mask(be)) | (data & byte_mask(be));
                exp_q.push_back('{addr[11:2], be, data});
            end
            op_imm: res = alu_ref(w[14:12], w[30], 1'b0, a, imm_i);
            op_reg: res = alu_ref(w[14:12], w[30], 1'b1, a, b);
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            r_x[w[11:7]] = res;
        end
        r_pc = nxt;
    endfunction

    task automatic gen_program();
        logic [2:0]  sel;
        logic [2:0]  f3;
        logic [2:0]  lf3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [1:0]  off;
        logic [1:0]  loff;
        int          base;
        pc_gen = 0;
        slot = 'h100;
        for (int r = 1; r < 16; r++) begin
            emit({20'(rnd(20)), 5'(r), op_lui});
            emit(enc_i(12'(rnd(12)), 5'(r), f3_add, 5'(r), op_imm));
        end
        // each store lane once then every load size from those words
        base = slot;
        for (int o = 0; o < 4; o++) begin
            emit(enc_s(12'(base + o), 5'(o + 1), 5'd0, f3_b));
        end
        for (int o = 0; o < 4; o += 2) begin
            emit(enc_s(12'(base + 4 + o), 5'(o + 5), 5'd0, f3_h));
        end
        slot += 8;
        emit(enc_i(12'(base + 3), 5'd0, f3_b, 5'd7, op_load));
        store_slot(5'd7);
        emit(enc_i(12'(base + 1), 5'd0, f3_bu, 5'd7, op_load));
        store_slot(5'd7);
        emit(enc_i(12'(base + 6), 5'd0, f3_h, 5'd7, op_load));
        store_slot(5'd7);
        emit(enc_i(12'(base + 4), 5'd0, f3_hu, 5'd7, op_load));
        store_slot(5'd7);
        emit(enc_i(12'(base), 5'd0, f3_w, 5'd7, op_load));
        store_slot(5'd7);
        for (int g = 0; g < 64; g++) begin
            sel = 3'(rnd(3));
            f3 = 3'(rnd(3));
            rd = 5'(rnd(4));
            rs1 = 5'(rnd(4));
            rs2 = 5'(rnd(4));
            case (sel)
                3'd0, 3'd1: begin
                    emit(enc_r({1'b0, (f3 == f3_add || f3 == f3_sr) && rnd(1) != 0, 5'b0},
                               rs2, rs1, f3, rd));
                    store_slot(rd);
                end
                3'd2: begin
                    imm = 12'(rnd(12));
                    if (f3 == f3_sll || f3 == f3_sr) begin
                        imm = {1'b0, f3 == f3_sr && rnd(1) != 0, 5'b0, imm[4:0]};
                    end
                    emit(enc_i(imm, rs1, f3, rd, op_imm));
                    store_slot(rd);
                end
                3'd3: begin
                    emit({20'(rnd(20)), rd, (rnd(1) != 0) ? op_lui : op_auipc});
                    store_slot(rd);
                end
                3'd4: begin
                    // jump over one store that must never appear
                    if (rnd(1) != 0) begin
                        emit(enc_j(21'd8, rd));
                    end else begin
                        emit({20'd0, 5'd5, op_auipc});
                        emit(enc_i(12'd12, 5'd5, 3'd0, rd, op_jalr));
                    end
                    store_slot(5'd6);
                    store_slot(rd);
                end
                3'd5: begin
                    if (rnd(2) == 0) begin
                        rs2 = rs1;
                    end
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1;
                    end
                    emit(enc_b(13'd8, rs2, rs1, f3));
                    store_slot(rs1);
                    store_slot(rs2);
                end
                default: begin
                    off = 2'(rnd(2));
                    f3 = (off == 2'd3) ? f3_w : {1'b0, off};
                    off = (f3 == f3_b) ? 2'(rnd(2)) : (f3 == f3_h) ? {1'(rnd(1)), 1'b0} : 2'd0;
                    emit(enc_s(12'(slot) + 12'(off), rs2, 5'd0, f3));
                    case (3'(rnd(3)))
                        3'd0, 3'd5: lf3 = f3_b;
                        3'd1, 3'd6: lf3 = f3_bu;
                        3'd2, 3'd7: lf3 = f3_h;
                        3'd3: lf3 = f3_hu;
                        default: lf3 = f3_w;
                    endcase
                    loff = (lf3 == f3_w) ? 2'd0 : 2'(rnd(2));
                    if (lf3 == f3_h || lf3 == f3_hu) begin
                        loff[0] = 1'b0;
                    end
                    emit(enc_i(12'(slot) + 12'(loff), 5'd0, lf3, rd, op_load));
                    slot += 4;
                    store_slot(rd);
                end
            endcase
        end
        end_pc = 32'(pc_gen * 4);
        emit(enc_j(21'd0, 5'd0));
    endtask

    always @(posedge clk) begin
        d_inst <= imem[a_inst];
        // read data only follows a read strobe
        ld_mem <= mem_read_flag ? dmem[a_mem] : ~dmem[a_mem];
        if (mem_write_flag != '0) begin
            dmem[a_mem] <= (dmem[a_mem] & ~byte_mask(mem_write_flag))
                           | (sd_mem & byte_mask(mem_write_flag));
        end
    end

    // compare each write strobe with the next expected store
    always @(negedge clk) begin
        store_t head;
        if (rstn && mem_write_flag != '0) begin
            assert (exp_q.size() != 0) else begin
                $display("ERR %0t: write strobe with no store expected", $time);
                $display("TEST FAIL");
                $fatal(1);
            end
            head = exp_q.pop_front();
            assert (a_mem == head.addr && mem_write_flag == head.be && sd_mem == head.data)
            else begin
                $display("ERR %0t: store addr %h be %b data %h, expected addr %h be %b data %h",
                         $time, a_mem, mem_write_flag, sd_mem, head.addr, head.be, head.data);
                $display("TEST FAIL");
                $fatal(1);
            end
        end
    end

    initial begin
        wait (gen_done);
        #(real'(pc_gen * 9 + 200) * 4.0);
        $display("watchdog expired before all expected stores were seen");
        $display("TEST FAIL");
        $fatal(1);
    end

    initial begin
        rstn = 1'b0;
        d_inst = '0;
        ld_mem = '0;
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = '0;
            dmem[10'(i)] = (32'(i) * 32'h9e3779b9) ^ 32'h0f1e2d3c;
            r_mem[10'(i)] = dmem[10'(i)];
        end
        for (int i = 0; i < 32; i++) begin
            r_x[5'(i)] = '0;
        end
        gen_program();
        r_pc = '0;
        while (r_pc != end_pc) begin
            ref_exec();
        end
        gen_done = 1'b1;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a few turns of the final loop to catch stray strobes
        repeat (21) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- vlog.f
common/cpu_pkg.sv
verilog/regs.sv
verilog/fetch.sv
decode/decode.sv
verilog/alu.sv
verilog/memory.sv
cpu/cpu.sv
tb/cpu_asserts.sv
tb/cpu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -f vlog.f --top-module cpu_tb &&
./obj_dir/Vcpu_tb || exit 1
